//--- fetch_top.f
+incdir+.
fetch_pkg.sv
inst_cache.sv
inst_fetch.sv
fetch_out_buffer.sv
fetch_top.sv
tb_fetch_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator and runs it.
# Exit status is 0 only when the run reports a pass.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f fetch_top.f \
	--top-module tb_fetch_top \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_fetch_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

//--- tb_fetch_tests.svh
// ####################################################################
// Decoder side helpers
// ####################################################################

// out_ready only changes right after a falling edge
task automatic get_item(output fetch_out_t item);
	logic done;
	done = 1'b0;
	while (!done) begin
		@(negedge clock);
		if (rand_ready) begin
			ready_rng = xorshift(ready_rng);
			out_ready = ready_rng[3];
		end else
			out_ready = 1'b1;
		if (out_valid && out_ready) begin
			item = out;
			done = 1'b1;
		end
	end
endtask

task automatic expect_run(input logic [31:0] start_pc, input int count);
	fetch_out_t item;
	for (int i = 0; i < count; i++) begin
		get_item(item);
		check_out("out", item, expected_item(start_pc + 32'(4 * i)));
	end
endtask

// Fill the buffer so no read is outstanding before the jump
task automatic stall_and_redirect(input logic [31:0] target);
	repeat (STALL_CYCLES) begin
		@(negedge clock);
		out_ready = 1'b0;
	end
	@(negedge clock);
	redirect.valid = 1'b1;
	redirect.pc    = target;
	@(negedge clock);
	redirect = '0;
endtask

// ####################################################################
// Directed tests
// ####################################################################

task automatic reset_fetch_test();
	int err0;
	err0 = errors;
	expect_run(`FETCH_RESET_PC, 6);
	check_count("ar handshakes", ar_count, 6); // One single beat per word
	report("reset_fetch", err0);
endtask

task automatic cached_refill_test();
	int err0;
	int base;
	int base_incr;
	err0 = errors;
	stall_and_redirect(32'ha000_0100);
	base      = ar_count;
	base_incr = incr_count;
	expect_run(32'ha000_0100, 8);
	check_count("ar handshakes", ar_count - base, 2);
	check_count("four beat bursts", incr_count - base_incr, 2);
	report("cached_refill", err0);
endtask

task automatic cache_hit_test();
	int err0;
	int base;
	int lat;
	err0 = errors;
	stall_and_redirect(32'ha000_0100);
	base = ar_count;
	lat  = 0;
	// Lookup goes out in the cycle after the redirect edge
	do begin
		@(negedge clock);
		out_ready = 1'b1;
		lat++;
	end while (!out_valid);
	check_count("hit latency", lat, 2);
	check_out("out", out, expected_item(32'ha000_0100));
	expect_run(32'ha000_0104, 7);
	check_count("ar handshakes", ar_count - base, 0);
	report("cache_hit", err0);
endtask

task automatic back_pressure_test();
	fetch_out_t held;
	int err0;
	err0 = errors;
	do begin
		@(negedge clock);
		out_ready = 1'b0;
	end while (!out_valid);
	held = out;
	check_out("out", held, expected_item(32'ha000_0120));
	repeat (20) begin
		@(negedge clock);
		out_ready = 1'b0;
		if (!out_valid) begin
			errors++;
			$display("out_valid dropped while the decoder was stalled");
		end
		check_out("out", out, held);
	end
	expect_run(32'ha000_0120, 9); // Held word comes first
	report("back_pressure", err0);
endtask

task automatic redirect_test();
	int err0;
	int base;
	err0 = errors;
	stall_and_redirect(32'ha000_0240); // Line not cached yet
	do begin
		@(negedge clock);
		out_ready = 1'b0;
	end while (!ar_valid);
	redirect.valid = 1'b1;
	redirect.pc    = 32'h3000_2000;
	@(negedge clock);
	redirect = '0;
	expect_run(32'h3000_2000, 4);
	// Abandoned refill still lands in the cache
	stall_and_redirect(32'ha000_0240);
	base = ar_count;
	expect_run(32'ha000_0240, 4);
	check_count("ar handshakes", ar_count - base, 0);
	report("redirect", err0);
endtask

task automatic random_ready_test();
	logic [31:0] starts [5];
	int err0;
	err0   = errors;
	// Third run crosses the end of the cacheable window
	starts = '{32'ha000_0100, 32'h3000_0040, 32'ha1ff_ffc0, 32'h3100_0000, 32'ha000_0240};
	rand_ready = 1'b1;
	foreach (starts[s]) begin
		stall_and_redirect(starts[s]);
		expect_run(starts[s], 20);
	end
	rand_ready = 1'b0;
	report("random_ready", err0);
endtask

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_top
	import fetch_pkg::*;
();

	localparam logic [31:0] MEM_PATTERN = 32'h5a5a_0000;
	localparam int STALL_CYCLES = 64;
	// About 140 items at a refill worst case of 24 cycles each plus the stall windows
	localparam int TOTAL_ITEMS = 140;
	localparam int WORST_ITEM_CYCLES = 24;
	localparam int MARGIN_CYCLES = 640;
	localparam int MAX_CYCLES = TOTAL_ITEMS * WORST_ITEM_CYCLES + MARGIN_CYCLES;

	logic       clock = 1'b0;
	logic       arst_n;
	redirect_t  redirect;
	logic       ar_valid;
	logic       ar_ready = 1'b0;
	axi_ar_t    ar;
	logic       r_valid = 1'b0;
	logic       r_ready;
	axi_r_t     r = '0;
	logic       out_valid;
	logic       out_ready;
	fetch_out_t out;

	// AXI memory model state
	logic [31:0] mem [logic [31:0]];
	axi_ar_t     rd_ar;          // Request being served
	logic [31:0] rd_addr;
	int          beats_left;
	int          ar_wait;
	int          r_wait;
	int          ar_count;
	int          incr_count;     // Aligned four-beat INCR bursts
	logic [31:0] mem_rng = 32'h690f;
	logic [31:0] ready_rng = 32'h690f;

	logic rand_ready;
	int   cycles;
	int   checks;
	int   errors;
	int   tests_run;

	fetch_top DUT (
		.clock     (clock),
		.arst_n    (arst_n),
		.redirect  (redirect),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.ar        (ar),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.r         (r),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Words appear on first touch
	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (!mem.exists(addr))
			mem[addr] = addr ^ MEM_PATTERN;
		return mem[addr];
	endfunction

	function automatic fetch_out_t expected_item(input logic [31:0] pc);
		fetch_out_t item;
		item.pc   = pc;
		item.inst = pc ^ MEM_PATTERN;
		return item;
	endfunction

	// ####################################################################
	// AXI read slave serving one request at a time
	// ####################################################################

	always @(negedge clock) begin
		if (!arst_n) begin
			ar_ready   = 1'b0;
			r_valid    = 1'b0;
			beats_left = 0;
			ar_wait    = 0;
			r_wait     = 0;
			ar_count   = 0;
			incr_count = 0;
		end else begin
			if (r_valid) begin // Beat offered on the last rising edge
				check_bit("r_ready", r_ready, 1'b1);
				r_valid = 1'b0;
				beats_left--;
				if (rd_ar.arburst == `AXI_BURST_INCR)
					rd_addr = rd_addr + 32'd4;
				mem_rng = xorshift(mem_rng);
				r_wait  = int'(mem_rng[1:0]);
			end
			if (ar_ready) begin // Raised only under ar_valid so the handshake happened
				ar_ready = 1'b0;
				ar_count++;
				if (rd_ar.arburst == `AXI_BURST_INCR && rd_ar.arlen == 8'd3 &&
						rd_ar.araddr[3:0] == 4'h0)
					incr_count++;
				rd_addr    = rd_ar.araddr;
				beats_left = int'(rd_ar.arlen) + 1;
				mem_rng    = xorshift(mem_rng);
				ar_wait    = int'(mem_rng[3:2]);
				r_wait     = int'(mem_rng[1:0]);
			end else if (ar_valid && beats_left == 0) begin
				if (ar_wait == 0) begin
					ar_ready = 1'b1;
					rd_ar    = ar;
				end else
					ar_wait--;
			end
			if (beats_left > 0 && !r_valid) begin
				if (r_wait == 0) begin
					r_valid = 1'b1;
					r.rdata = mem_read(rd_addr);
					r.rresp = 2'b00;
					r.rlast = (beats_left == 1);
				end else
					r_wait--;
			end
		end
	end

	// ####################################################################
	// Checks and reporting
	// ####################################################################

	task automatic check_out(input string name, input fetch_out_t got, input fetch_out_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got pc %h inst %h, expected pc %h inst %h",
				name, got.pc, got.inst, exp.pc, exp.inst);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Fail %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errors - err0);
	endtask

	`include "tb_fetch_tests.svh"

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the fetch stream stopped", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		arst_n     = 1'b0;
		redirect   = '0;
		out_ready  = 1'b0;
		rand_ready = 1'b0;
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		reset_fetch_test();
		cached_refill_test();
		cache_hit_test();
		back_pressure_test();
		redirect_test();
		random_ready_test();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top
	import fetch_pkg::*;
(
	input  logic       clock,
	input  logic       arst_n,
	input  redirect_t  redirect,
	output logic       ar_valid,
	input  logic       ar_ready,
	output axi_ar_t    ar,
	input  logic       r_valid,
	output logic       r_ready,
	input  axi_r_t     r,
	output logic       out_valid,
	input  logic       out_ready,
	output fetch_out_t out
);

	// Cache port
	logic        lookup_valid;
	logic [31:0] lookup_addr;
	cache_resp_t lookup_resp;
	logic        fill_valid;
	cache_fill_t fill;

	// Toward the output buffer
	logic        push_valid;
	logic        push_ready;
	fetch_out_t  push;
	logic        flush;

	inst_fetch u_fetch (
		.clock        (clock),
		.arst_n       (arst_n),
		.redirect     (redirect),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.ar           (ar),
		.r_valid      (r_valid),
		.r_ready      (r_ready),
		.r            (r),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.lookup_resp  (lookup_resp),
		.fill_valid   (fill_valid),
		.fill         (fill),
		.push_valid   (push_valid),
		.push_ready   (push_ready),
		.push         (push),
		.flush        (flush)
	);

	inst_cache u_cache (
		.clock        (clock),
		.arst_n       (arst_n),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.lookup_resp  (lookup_resp),
		.fill_valid   (fill_valid),
		.fill         (fill)
	);

	fetch_out_buffer u_out_buf (
		.clock      (clock),
		.arst_n     (arst_n),
		.flush      (flush),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.push       (push),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out        (out)
	);

endmodule

//--- fetch_out_buffer.sv
`timescale 1ns/1ps

module fetch_out_buffer
	import fetch_pkg::*;
(
	input  logic       clock,
	input  logic       arst_n,
	input  logic       flush,
	input  logic       push_valid,
	output logic       push_ready,
	input  fetch_out_t push,
	output logic       out_valid,
	input  logic       out_ready,
	output fetch_out_t out
);

	fetch_out_t main_q;  // Drives the decoder
	fetch_out_t skid_q;
	logic       main_v;
	logic       skid_v;
	logic       main_free;

	assign main_free  = !main_v || out_ready;
	assign push_ready = !skid_v; // Registered, no path from out_ready
	assign out_valid  = main_v;
	assign out        = main_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			main_v <= 1'b0;
			skid_v <= 1'b0;
		end else if (flush) begin
			main_v <= 1'b0;
			skid_v <= 1'b0;
		end else if (main_free) begin
			main_v <= skid_v || push_valid;
			skid_v <= 1'b0;
		end else if (push_valid && push_ready) begin
			skid_v <= 1'b1; // Decoder stalled, park the item
		end
	end

	always_ff @(posedge clock) begin
		if (main_free)
			main_q <= skid_v ? skid_q : push;
		if (!main_free && push_valid && push_ready)
			skid_q <= push;
	end

	out_hold_a: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready && !flush |=> out_valid && $stable(out));

endmodule

//--- inst_fetch.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_fetch
	import fetch_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  redirect_t   redirect,
	output logic        ar_valid,
	input  logic        ar_ready,
	output axi_ar_t     ar,
	input  logic        r_valid,
	output logic        r_ready,
	input  axi_r_t      r,
	output logic        lookup_valid,
	output logic [31:0] lookup_addr,
	input  cache_resp_t lookup_resp,
	output logic        fill_valid,
	output cache_fill_t fill,
	output logic        push_valid,
	input  logic        push_ready,
	output fetch_out_t  push,
	output logic        flush
);

	localparam int          WORD_W    = $clog2(`LINE_WORDS);
	localparam logic [31:0] LINE_MASK = 32'(`LINE_WORDS * 4 - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_AR,
		S_RD,
		S_PUSH
	} state_t;

	state_t      state_q;
	state_t      state_d;
	logic [31:0] pc_q;
	logic        pending_q;    // Redirect seen while a read was outstanding
	axi_ar_t     ar_q;
	logic [31:0] fill_addr_q;
	logic [31:0] inst_q;

	logic pc_cached;
	logic hit;
	logic beat;
	logic last_beat;
	logic burst;
	logic capture;
	logic push_done;

	// ####################################################################
	// Decode of the current cycle
	// ####################################################################

	assign pc_cached = (pc_q >= `CACHE_BASE) && (pc_q < `CACHE_LIMIT);
	assign hit       = (state_q == S_LOOKUP) && lookup_resp.hit;
	assign beat      = (state_q == S_RD) && r_valid;
	assign last_beat = beat && r.rlast;
	assign burst     = (ar_q.arburst == `AXI_BURST_INCR);

	// Keep only the word the pc asked for
	assign capture = beat && (!burst || fill_addr_q[2 +: WORD_W] == pc_q[2 +: WORD_W]);

	assign lookup_valid = (state_q == S_IDLE) && pc_cached;
	assign lookup_addr  = pc_q;

	assign ar_valid = (state_q == S_AR);
	assign ar       = ar_q;
	assign r_ready  = 1'b1;

	assign fill_valid = beat && burst;
	assign fill.addr  = fill_addr_q;
	assign fill.data  = r.rdata;

	// Hits go straight to the buffer and other results wait in S_PUSH
	assign push_valid = !redirect.valid && (hit || state_q == S_PUSH);
	assign push.pc    = pc_q;
	assign push.inst  = (state_q == S_PUSH) ? inst_q : lookup_resp.inst;
	assign push_done  = push_valid && push_ready;

	assign flush = redirect.valid;

	// ####################################################################
	// FSM
	// ####################################################################

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (!redirect.valid)
					state_d = pc_cached ? S_LOOKUP : S_AR;
			end
			S_LOOKUP: begin
				if (redirect.valid)
					state_d = S_IDLE;
				else if (hit)
					state_d = push_ready ? S_IDLE : S_PUSH;
				else
					state_d = S_AR; // Miss refills the line
			end
			S_AR: begin
				if (ar_ready)
					state_d = S_RD;
			end
			S_RD: begin
				// Burst always runs to rlast
				if (last_beat)
					state_d = (pending_q || redirect.valid) ? S_IDLE : S_PUSH;
			end
			S_PUSH: begin
				if (redirect.valid || push_ready)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q   <= S_IDLE;
			pc_q      <= `FETCH_RESET_PC;
			pending_q <= 1'b0;
		end else begin
			state_q <= state_d;

			if (redirect.valid)
				pc_q <= redirect.pc;
			else if (push_done)
				pc_q <= pc_q + 32'd4;

			if (last_beat)
				pending_q <= 1'b0;
			else if (redirect.valid && (state_q == S_AR || state_q == S_RD))
				pending_q <= 1'b1;
		end
	end

	// ####################################################################
	// Request and result registers
	// ####################################################################

	always_ff @(posedge clock) begin
		if (state_q == S_IDLE && !pc_cached) begin
			ar_q.araddr  <= pc_q;
			ar_q.arlen   <= 8'd0;
			ar_q.arburst <= `AXI_BURST_FIXED;
		end else if (state_q == S_LOOKUP && !lookup_resp.hit) begin
			ar_q.araddr  <= pc_q & ~LINE_MASK; // Line aligned
			ar_q.arlen   <= 8'(`LINE_WORDS - 1);
			ar_q.arburst <= `AXI_BURST_INCR;
		end

		if (state_q == S_LOOKUP)
			fill_addr_q <= pc_q & ~LINE_MASK;
		else if (fill_valid)
			fill_addr_q <= fill_addr_q + 32'd4;

		if (hit)
			inst_q <= lookup_resp.inst;
		else if (capture)
			inst_q <= r.rdata;
	end

	// AR payload must not move before the handshake
	ar_stable_a: assert property (@(posedge clock) disable iff (!arst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

	// Cache answers only the lookup of the cycle before
	hit_after_lookup_a: assert property (@(posedge clock) disable iff (!arst_n)
		lookup_resp.hit |-> $past(lookup_valid));

endmodule

//--- inst_cache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_cache
	import fetch_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  logic        lookup_valid,
	input  logic [31:0] lookup_addr,
	output cache_resp_t lookup_resp,
	input  logic        fill_valid,
	input  cache_fill_t fill
);

	localparam int WORD_W   = $clog2(`LINE_WORDS);
	localparam int OFFSET_W = WORD_W + 2;
	localparam int INDEX_W  = $clog2(`CACHE_LINES);
	localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

	logic [TAG_W-1:0]       tag_mem  [`CACHE_LINES];
	logic [31:0]            data_mem [`CACHE_LINES][`LINE_WORDS];
	logic [`CACHE_LINES-1:0] valid_q;

	logic               hit_q;
	logic [31:0]        inst_q;

	// Lookup address fields
	logic [INDEX_W-1:0] l_index;
	logic [WORD_W-1:0]  l_word;
	logic [TAG_W-1:0]   l_tag;

	// Fill address fields
	logic [INDEX_W-1:0] f_index;
	logic [WORD_W-1:0]  f_word;
	logic [TAG_W-1:0]   f_tag;
	logic               f_first;
	logic               f_last;

	assign l_index = lookup_addr[OFFSET_W +: INDEX_W];
	assign l_word  = lookup_addr[2 +: WORD_W];
	assign l_tag   = lookup_addr[31 -: TAG_W];

	assign f_index = fill.addr[OFFSET_W +: INDEX_W];
	assign f_word  = fill.addr[2 +: WORD_W];
	assign f_tag   = fill.addr[31 -: TAG_W];
	assign f_first = (f_word == '0);
	assign f_last  = (f_word == WORD_W'(`LINE_WORDS - 1));

	// ####################################################################
	// Lookup, answered one cycle later
	// ####################################################################

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			hit_q <= 1'b0;
		else
			hit_q <= lookup_valid && valid_q[l_index] && (tag_mem[l_index] == l_tag);
	end

	always_ff @(posedge clock) begin
		if (lookup_valid)
			inst_q <= data_mem[l_index][l_word];
	end

	assign lookup_resp.hit  = hit_q;
	assign lookup_resp.inst = inst_q;

	// ####################################################################
	// Line fill
	// ####################################################################

	// Line is invalid while it is half written
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			valid_q <= '0;
		else if (fill_valid && f_last)
			valid_q[f_index] <= 1'b1;
		else if (fill_valid && f_first)
			valid_q[f_index] <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[f_index][f_word] <= fill.data;
			if (f_last)
				tag_mem[f_index] <= f_tag;
		end
	end

	// Only SDRAM lines are ever refilled
	fill_window_a: assert property (@(posedge clock) disable iff (!arst_n)
		fill_valid |-> (fill.addr >= `CACHE_BASE) && (fill.addr < `CACHE_LIMIT));

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

	// Item handed to the decoder
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_out_t;

	// Single-cycle pulse from later stages
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
	} redirect_t;

	// AXI read address channel payload
	typedef struct packed {
		logic [31:0] araddr;
		logic [7:0]  arlen;
		logic [1:0]  arburst;
	} axi_ar_t;

	// AXI read data channel payload
	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0]  rresp; // Carried, never checked
		logic        rlast;
	} axi_r_t;

	// One refill beat into the cache
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} cache_fill_t;

	// Registered lookup answer
	typedef struct packed {
		logic        hit;
		logic [31:0] inst;
	} cache_resp_t;

endpackage

//--- fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ####################################################################
// Program counter
// ####################################################################

`define FETCH_RESET_PC 32'h3000_0000

// ####################################################################
// SDRAM window served through the instruction cache
// ####################################################################

`define CACHE_BASE  32'ha000_0000 // Inclusive
`define CACHE_LIMIT 32'ha200_0000 // Exclusive

`define LINE_WORDS  4  // 16-byte lines
`define CACHE_LINES 16

// AXI burst types
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01

`endif
